/* design/mdc_clock_gen.sv */
`timescale 1ns/100ps

module mdc_clock_gen import mdio_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic mdc_o,
    output logic mdc_rise_o,
    output logic mdc_fall_o
);

    // Divider counter that runs from 0 to MDC_HALF_CYCLES-1
    logic [MDC_CNT_W-1:0] div_cnt;
    logic                 div_wrap;

    // MDC toggles on the clock that ends each half period
    assign div_wrap = (div_cnt == MDC_CNT_W'(MDC_HALF_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt    <= '0;
            mdc_o      <= 1'b0;
            mdc_rise_o <= 1'b0;
            mdc_fall_o <= 1'b0;
        end else begin
            // Strobes are single pulses unless MDC changes on this clock
            mdc_rise_o <= 1'b0;
            mdc_fall_o <= 1'b0;
            if (div_wrap) begin
                div_cnt <= '0;
                mdc_o   <= ~mdc_o;
                // The strobe matching the new MDC level rises with it
                mdc_rise_o <= ~mdc_o;
                mdc_fall_o <= mdc_o;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // MDC runs freely from reset
    // The strobes are high during the first clk cycle after MDC changes level
    // Downstream logic acts on them instead of on MDC itself

endmodule

/* design/mdio_control.sv */
`timescale 1ns/100ps

module mdio_control import mdio_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mdc_rise_i,
    input  logic                  mdc_fall_i,
    input  logic                  req_valid_i,
    input  logic                  req_write_i,
    input  logic [REG_ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0]     req_wdata_i,
    output logic                  req_taken_o,
    output logic                  resp_valid_o,
    output logic                  mdio_t_o,
    mdio_frame_if.ctrl            frame
);

    mdio_state_e           state_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [BIT_CNT_W-1:0]  next_bit;
    logic                  is_read_q;
    logic                  last_bit;
    logic                  data_phase;

    // Index of the bit that the next falling strobe puts on the line
    assign next_bit = bit_cnt_q + 1'b1;
    assign last_bit = (bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1));

    // The sixteen data bits follow the two turnaround bits
    assign data_phase = (bit_cnt_q >= BIT_CNT_W'(TA_FIRST_BIT + 2));

    // Request fields go straight to the shifter and are used on the load pulse
    assign frame.op       = req_write_i ? MDIO_OP_WRITE : MDIO_OP_READ;
    assign frame.reg_addr = req_addr_i;
    assign frame.wdata    = req_wdata_i;

    // Frame starts on a falling edge and the request is consumed with it
    assign frame.load = (state_q == ST_ALIGN) && mdc_fall_i;
    assign req_taken_o = frame.load;

    // One shift per falling edge until bit 31 is on the line
    assign frame.shift_en = (state_q == ST_FRAME) && mdc_fall_i && !last_bit;

    // Read data is sampled on MDC rising edges during the data phase
    assign frame.capture_en = (state_q == ST_FRAME) && mdc_rise_i && is_read_q && data_phase;

    // Response pulse lasts the single clock spent in the respond state
    assign resp_valid_o = (state_q == ST_RESPOND);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= '0;
            is_read_q <= 1'b0;
            mdio_t_o  <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= ST_ALIGN;
                    end
                end
                ST_ALIGN: begin
                    // The master drives the line from the first start bit
                    if (mdc_fall_i) begin
                        bit_cnt_q <= '0;
                        is_read_q <= !req_write_i;
                        mdio_t_o  <= 1'b0;
                        state_q   <= ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (mdc_fall_i) begin
                        if (last_bit) begin
                            // Bit 31 has ended so the line is released
                            mdio_t_o <= 1'b1;
                            state_q  <= ST_RESPOND;
                        end else begin
                            bit_cnt_q <= next_bit;
                            // A read hands the line to the PHY at the turnaround
                            if (is_read_q && next_bit == BIT_CNT_W'(TA_FIRST_BIT)) begin
                                mdio_t_o <= 1'b1;
                            end
                        end
                    end
                end
                ST_RESPOND: begin
                    state_q <= ST_GAP;
                end
                ST_GAP: begin
                    // Wait one full MDC period before the next frame may align
                    // The host port holds off new requests until its response transfers
                    if (mdc_fall_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q  <= ST_IDLE;
                    mdio_t_o <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* design/mdio_frame_if.sv */
`timescale 1ns/100ps

// Link between the control FSM and the frame shift register
interface mdio_frame_if import mdio_pkg::*; ();

    // Request fields and strobes from the control side
    logic                  load;
    mdio_op_e              op;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0]     wdata;
    logic                  shift_en;
    logic                  capture_en;

    // Current output bit and captured read data from the shifter side
    logic                  mdio_bit;
    logic [DATA_W-1:0]     rdata;

    modport ctrl (
        output load, op, reg_addr, wdata, shift_en, capture_en
    );

    modport shift (
        input  load, op, reg_addr, wdata, shift_en, capture_en,
        output mdio_bit, rdata
    );

endinterface

/* design/mdio_frame_shifter.sv */
`timescale 1ns/100ps

module mdio_frame_shifter import mdio_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         mdio_i,
    mdio_frame_if.shift frame
);

    // Frame register that sends its MSB first
    logic [FRAME_BITS-1:0] frame_q;

    // Read data collects MSB first as the PHY sends it
    logic [DATA_W-1:0] rdata_q;

    // Full clause-22 frame as one word
    logic [FRAME_BITS-1:0] frame_word;

    assign frame_word = {
        START_CODE,
        frame.op,
        PHY_ADDR,
        frame.reg_addr,
        TA_PATTERN,
        frame.wdata
    };

    // Frame register loads on the aligning strobe and shifts once per falling strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_q <= '0;
        end else if (frame.load) begin
            frame_q <= frame_word;
        end else if (frame.shift_en) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    // Each capture strobe moves one sampled MDIO bit in at the LSB
    always_ff @(posedge clk) begin
        if (frame.capture_en) begin
            rdata_q <= {rdata_q[DATA_W-2:0], mdio_i};
        end
    end

    // The current bit is always the top of the register
    assign frame.mdio_bit = frame_q[FRAME_BITS-1];
    assign frame.rdata    = rdata_q;

    // A load on a falling strobe puts the first start bit on the pin at once
    // After sixteen captures the read data word is complete

endmodule

/* design/mdio_host_port.sv */
`timescale 1ns/100ps

module mdio_host_port import mdio_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    // Write address channel
    input  logic                  awvalid_i,
    input  logic [REG_ADDR_W-1:0] awaddr_i,
    output logic                  awready_o,

    // Write data channel
    input  logic                  wvalid_i,
    input  logic [DATA_W-1:0]     wdata_i,
    output logic                  wready_o,

    // Write response channel
    output logic                  bvalid_o,
    output logic [1:0]            bresp_o,
    input  logic                  bready_i,

    // Read address channel
    input  logic                  arvalid_i,
    input  logic [REG_ADDR_W-1:0] araddr_i,
    output logic                  arready_o,

    // Read data channel
    output logic                  rvalid_o,
    output logic [DATA_W-1:0]     rdata_o,
    output logic [1:0]            rresp_o,
    input  logic                  rready_i,

    // Pending request towards the control FSM
    output logic                  req_valid_o,
    output logic                  req_write_o,
    output logic [REG_ADDR_W-1:0] req_addr_o,
    output logic [DATA_W-1:0]     req_wdata_o,
    input  logic                  req_taken_i,
    input  logic                  resp_valid_i,
    input  logic [DATA_W-1:0]     rdata_i
);

    logic ar_xfer;
    logic aw_xfer;
    logic w_xfer;

    // Read wins when both address channels are valid on the same clock
    assign ar_xfer = arvalid_i && arready_o;
    assign aw_xfer = awvalid_i && awready_o && !ar_xfer;
    assign w_xfer  = wvalid_i && wready_o;

    // Every response is OKAY
    assign bresp_o = RESP_OKAY;
    assign rresp_o = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            awready_o   <= 1'b1;
            arready_o   <= 1'b1;
            wready_o    <= 1'b0;
            bvalid_o    <= 1'b0;
            rvalid_o    <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            // Any address beat closes both address channels
            if (ar_xfer || aw_xfer) begin
                awready_o <= 1'b0;
                arready_o <= 1'b0;
            end
            // A read is complete with its address beat
            // A write still needs its data beat
            if (ar_xfer) begin
                req_valid_o <= 1'b1;
            end
            if (aw_xfer) begin
                wready_o <= 1'b1;
            end
            if (w_xfer) begin
                wready_o    <= 1'b0;
                req_valid_o <= 1'b1;
            end
            if (req_taken_i) begin
                req_valid_o <= 1'b0;
            end
            // Response goes to the channel of the latched request type
            if (resp_valid_i) begin
                bvalid_o <= req_write_o;
                rvalid_o <= !req_write_o;
            end
            // Address channels reopen only once the response has transferred
            if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
                bvalid_o  <= 1'b0;
                rvalid_o  <= 1'b0;
                awready_o <= 1'b1;
                arready_o <= 1'b1;
            end
        end
    end

    // Request fields follow the host beats and read data follows the response pulse
    always_ff @(posedge clk) begin
        if (ar_xfer) begin
            req_write_o <= 1'b0;
            req_addr_o  <= araddr_i;
            // Known data bits keep the released part of a read frame clean
            req_wdata_o <= '0;
        end else if (aw_xfer) begin
            req_write_o <= 1'b1;
            req_addr_o  <= awaddr_i;
        end
        if (w_xfer) begin
            req_wdata_o <= wdata_i;
        end
        // Read data holds steady while rvalid waits for rready
        if (resp_valid_i && !req_write_o) begin
            rdata_o <= rdata_i;
        end
    end

endmodule

/* design/mdio_master.sv */
`timescale 1ns/100ps

module mdio_master import mdio_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    // Host write channels
    input  logic                  awvalid_i,
    input  logic [REG_ADDR_W-1:0] awaddr_i,
    output logic                  awready_o,
    input  logic                  wvalid_i,
    input  logic [DATA_W-1:0]     wdata_i,
    output logic                  wready_o,
    output logic                  bvalid_o,
    output logic [1:0]            bresp_o,
    input  logic                  bready_i,

    // Host read channels
    input  logic                  arvalid_i,
    input  logic [REG_ADDR_W-1:0] araddr_i,
    output logic                  arready_o,
    output logic                  rvalid_o,
    output logic [DATA_W-1:0]     rdata_o,
    output logic [1:0]            rresp_o,
    input  logic                  rready_i,

    // MDIO pins where mdio_t_o high means the line is released
    output logic                  mdc_o,
    input  logic                  mdio_i,
    output logic                  mdio_o,
    output logic                  mdio_t_o
);

    logic                  mdc_rise;
    logic                  mdc_fall;
    logic                  req_valid;
    logic                  req_write;
    logic [REG_ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0]     req_wdata;
    logic                  req_taken;
    logic                  resp_valid;

    mdio_frame_if frame_if ();

    mdc_clock_gen u_clock_gen (
        .clk        (clk),
        .reset      (reset),
        .mdc_o      (mdc_o),
        .mdc_rise_o (mdc_rise),
        .mdc_fall_o (mdc_fall)
    );

    mdio_host_port u_host_port (
        .clk (clk), .reset (reset),
        .awvalid_i (awvalid_i), .awaddr_i (awaddr_i), .awready_o (awready_o),
        .wvalid_i (wvalid_i), .wdata_i (wdata_i), .wready_o (wready_o),
        .bvalid_o (bvalid_o), .bresp_o (bresp_o), .bready_i (bready_i),
        .arvalid_i (arvalid_i), .araddr_i (araddr_i), .arready_o (arready_o),
        .rvalid_o (rvalid_o), .rdata_o (rdata_o), .rresp_o (rresp_o), .rready_i (rready_i),
        .req_valid_o (req_valid), .req_write_o (req_write),
        .req_addr_o (req_addr), .req_wdata_o (req_wdata),
        .req_taken_i (req_taken), .resp_valid_i (resp_valid),
        .rdata_i (frame_if.rdata)
    );

    mdio_control u_control (
        .clk (clk), .reset (reset),
        .mdc_rise_i (mdc_rise), .mdc_fall_i (mdc_fall),
        .req_valid_i (req_valid), .req_write_i (req_write),
        .req_addr_i (req_addr), .req_wdata_i (req_wdata),
        .req_taken_o (req_taken), .resp_valid_o (resp_valid),
        .mdio_t_o (mdio_t_o), .frame (frame_if.ctrl)
    );

    mdio_frame_shifter u_shifter (
        .clk (clk), .reset (reset), .mdio_i (mdio_i), .frame (frame_if.shift)
    );

    // Output data is the current bit of the frame register
    assign mdio_o = frame_if.mdio_bit;

endmodule

/* design/mdio_pkg.sv */
package mdio_pkg;

    // Address of the one PHY this master manages
    localparam logic [4:0] PHY_ADDR = 5'h0c;

    // Register address and register data widths of a clause-22 frame
    localparam int REG_ADDR_W = 5;
    localparam int DATA_W = 16;

    // A full frame is 32 MDC cycles
    localparam int FRAME_BITS = 32;

    // Start code and the turnaround pattern driven by the master on writes
    localparam logic [1:0] START_CODE = 2'b01;
    localparam logic [1:0] TA_PATTERN = 2'b10;

    // Index of the first turnaround bit when counted from the frame start
    localparam int TA_FIRST_BIT = 14;

    // Host responses are always OKAY
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // MDC half period in clk cycles, so one MDC period is 8 clk cycles
    localparam int MDC_HALF_CYCLES = 4;
    localparam int MDC_CNT_W = $clog2(MDC_HALF_CYCLES);

    // Frame bit counter covers bits 0 to 31
    localparam int BIT_CNT_W = 5;

    // Clause-22 opcodes as they appear on the wire
    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_e;

    // Control FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ALIGN,
        ST_FRAME,
        ST_RESPOND,
        ST_GAP
    } mdio_state_e;

endpackage

/* mdio_master.f */
design/mdio_pkg.sv
design/mdio_frame_if.sv
design/mdc_clock_gen.sv
design/mdio_host_port.sv
design/mdio_frame_shifter.sv
design/mdio_control.sv
design/mdio_master.sv
verif/mdio_master_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f mdio_master.f \
    --top-module mdio_master_tb -o mdio_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/mdio_sim > sim.log 2>&1 \
    || { echo "Simulation did not exit cleanly, see sim.log"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

/* verif/mdio_golden.txt */
# op addr data delay: op is W for write or R for read, addr and data in hex
# B is a read raised in the same cycle as the write on the next line
W 01 1234 0
R 02 abcd 0
W 1f ffff 3
R 00 0000 5
R 1f ffff 1
W 10 8001 7
B 05 5a5a 2
W 06 a5a5 4
R 11 7e81 2
W 0a 0000 0
R 15 c3c3 9

/* verif/mdio_master_tb.sv */
`timescale 1ns/100ps

module mdio_master_tb;

    // Expected MDC period in ns and the number of MDC periods allowed per transaction
    localparam int MDC_PERIOD_NS = 160;
    localparam int WD_MDC_PER_TRANS = 40;
    localparam logic [4:0] TB_PHY_ADDR = 5'h0c;

    logic        clk;
    logic        reset;
    logic        awvalid_i;
    logic [4:0]  awaddr_i;
    logic        awready_o;
    logic        wvalid_i;
    logic [15:0] wdata_i;
    logic        wready_o;
    logic        bvalid_o;
    logic [1:0]  bresp_o;
    logic        bready_i;
    logic        arvalid_i;
    logic [4:0]  araddr_i;
    logic        arready_o;
    logic        rvalid_o;
    logic [15:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        rready_i;
    logic        mdc_o;
    logic        mdio_i;
    logic        mdio_o;
    logic        mdio_t_o;

    // Golden transactions
    logic [7:0]  op_q[$];
    logic [4:0]  addr_q[$];
    logic [15:0] data_q[$];
    int          dly_q[$];
    int          n_trans = 0;
    int          errors = 0;
    int          exp_frames = 0;

    // PHY model state with frame bits stored MSB first as they appear on the wire
    logic        mon_active = 1'b0;
    int          mon_idx = 0;
    logic [31:0] frame_bits = '0;
    logic [31:0] tmask = '0;
    int          frames_done = 0;
    int          idle_rises = 0;
    logic        end_check = 1'b0;
    logic [15:0] cur_rdata = '0;

    // Time of the previous MDC rising edge
    time         last_rise_t = 0;
    int          mdc_rises = 0;

    mdio_master u_dut (.*);

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Rebuild each frame from the pin on MDC rising edges
    always @(posedge mdc_o) begin
        if (!reset) begin
            // MDC rising edges are one full MDC period apart
            if (mdc_rises > 0) begin
                check("mdc_o period", 32'($time - last_rise_t), MDC_PERIOD_NS);
            end
            mdc_rises++;
            last_rise_t = $time;
            if (end_check) begin
                end_check = 1'b0;
                if (!mdio_t_o) begin
                    $display("mdio_t_o still driven after bit 31, frame is too long");
                    errors++;
                end
            end
            if (!mon_active && !mdio_t_o) begin
                // One idle rise means one full idle MDC period before this frame
                if (frames_done > 0 && idle_rises < 1) begin
                    $display("Frame started less than one idle MDC period after the last");
                    errors++;
                end
                mon_active = 1'b1;
                mon_idx = 0;
            end
            if (mon_active) begin
                frame_bits[31-mon_idx] = mdio_o;
                tmask[31-mon_idx] = mdio_t_o;
                mon_idx++;
                if (mon_idx == 32) begin
                    mon_active = 1'b0;
                    frames_done++;
                    end_check = 1'b1;
                    idle_rises = 0;
                end
            end else begin
                idle_rises++;
            end
        end
    end

    // Read data goes out MSB first from the falling edge that starts bit 16
    always @(negedge mdc_o) begin
        if (mon_active && mon_idx >= 16 && frame_bits[29:28] == 2'b10) begin
            mdio_i <= cur_rdata[31-mon_idx];
        end else begin
            mdio_i <= 1'b1;
        end
    end

    task automatic do_aw(input logic [4:0] a);
        awvalid_i <= 1'b1;
        awaddr_i  <= a;
        do @(posedge clk); while (!awready_o);
        awvalid_i <= 1'b0;
    endtask

    task automatic do_w(input logic [15:0] d);
        wvalid_i <= 1'b1;
        wdata_i  <= d;
        do @(posedge clk); while (!wready_o);
        wvalid_i <= 1'b0;
    endtask

    task automatic do_ar(input logic [4:0] a, input logic [15:0] d);
        cur_rdata = d;
        arvalid_i <= 1'b1;
        araddr_i  <= a;
        do @(posedge clk); while (!arready_o);
        arvalid_i <= 1'b0;
    endtask

    // While the response waits, no channel may reopen and no frame may start
    task automatic check_hold();
        check("ready signals", {29'b0, awready_o, arready_o, wready_o}, 32'h0);
        check("frame active", {31'b0, mon_active}, 32'h0);
    endtask

    task automatic finish_write(input logic [4:0] a, input logic [15:0] d, input int dly);
        int i;
        do @(posedge clk); while (!bvalid_o);
        for (i = 0; i < dly; i++) begin
            @(posedge clk);
            check("bvalid_o", {31'b0, bvalid_o}, 32'h1);
            check_hold();
        end
        bready_i <= 1'b1;
        @(posedge clk);
        check("bvalid_o", {31'b0, bvalid_o}, 32'h1);
        check("bresp_o", {30'b0, bresp_o}, 32'h0);
        bready_i <= 1'b0;
        exp_frames++;
        check("frame count", frames_done, exp_frames);
        check("write frame", frame_bits, {2'b01, 2'b01, TB_PHY_ADDR, a, 2'b10, d});
        check("mdio_t_o per bit", tmask, 32'h0);
    endtask

    task automatic finish_read(input logic [4:0] a, input logic [15:0] d, input int dly);
        int i;
        do @(posedge clk); while (!rvalid_o);
        for (i = 0; i < dly; i++) begin
            @(posedge clk);
            check("rvalid_o", {31'b0, rvalid_o}, 32'h1);
            check("rdata_o", {16'b0, rdata_o}, {16'b0, d});
            check_hold();
        end
        rready_i <= 1'b1;
        @(posedge clk);
        check("rvalid_o", {31'b0, rvalid_o}, 32'h1);
        check("rdata_o", {16'b0, rdata_o}, {16'b0, d});
        check("rresp_o", {30'b0, rresp_o}, 32'h0);
        rready_i <= 1'b0;
        exp_frames++;
        check("frame count", frames_done, exp_frames);
        check("read frame head", {18'b0, frame_bits[31:18]},
              {18'b0, 2'b01, 2'b10, TB_PHY_ADDR, a});
        // Released from bit 14 to the end of the frame
        check("mdio_t_o per bit", tmask, 32'h0003_ffff);
    endtask

    // With read and write raised together the read frame must come first
    task automatic run_pair(input int r, input int w);
        awvalid_i <= 1'b1;
        awaddr_i  <= addr_q[w];
        do_ar(addr_q[r], data_q[r]);
        finish_read(addr_q[r], data_q[r], dly_q[r]);
        do_aw(addr_q[w]);
        do_w(data_q[w]);
        finish_write(addr_q[w], data_q[w], dly_q[w]);
    endtask

    initial begin
        int          fd;
        int          i;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        int          dly;
        clk = 1'b0;
        reset = 1'b1;
        awvalid_i = 1'b0;
        awaddr_i = '0;
        wvalid_i = 1'b0;
        wdata_i = '0;
        bready_i = 1'b0;
        arvalid_i = 1'b0;
        araddr_i = '0;
        rready_i = 1'b0;
        mdio_i = 1'b1;
        void'($urandom(32'hdf0b));
        fd = $fopen("verif/mdio_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file verif/mdio_golden.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 3 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %d", op, a, d, dly);
                    if (n == 4) begin
                        op_q.push_back(op);
                        addr_q.push_back(a[4:0]);
                        data_q.push_back(d[15:0]);
                        dly_q.push_back(dly);
                    end
                end
            end
            $fclose(fd);
            n_trans = op_q.size();
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            @(posedge clk);
            check("mdio_t_o after reset", {31'b0, mdio_t_o}, 32'h1);
            check("bvalid_o after reset", {31'b0, bvalid_o}, 32'h0);
            check("rvalid_o after reset", {31'b0, rvalid_o}, 32'h0);
            check("awready_o after reset", {31'b0, awready_o}, 32'h1);
            check("arready_o after reset", {31'b0, arready_o}, 32'h1);
            if (n_trans == 0) begin
                $display("The golden file holds no transactions");
                errors++;
            end
            i = 0;
            while (i < n_trans) begin
                // A short random pause between host requests
                repeat ($urandom_range(3)) @(posedge clk);
                if (op_q[i] == "B" && i + 1 < n_trans) begin
                    run_pair(i, i + 1);
                    i += 2;
                end else if (op_q[i] == "W") begin
                    do_aw(addr_q[i]);
                    do_w(data_q[i]);
                    finish_write(addr_q[i], data_q[i], dly_q[i]);
                    i++;
                end else begin
                    do_ar(addr_q[i], data_q[i]);
                    finish_read(addr_q[i], data_q[i], dly_q[i]);
                    i++;
                end
            end
            repeat (20) @(posedge clk);
            $display("Transactions %0d, frames %0d, errors %0d", n_trans, frames_done, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of golden transactions
    initial begin
        wait (n_trans > 0);
        #(longint'(n_trans) * WD_MDC_PER_TRANS * MDC_PERIOD_NS);
        $display("Timed out waiting for the DUT after %0d transactions, errors %0d",
                 n_trans, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
